//--- Bender.yml
package:
  name: fir_decim

export_include_dirs:
  - verilog

sources:
  - verilog/fir_pkg.sv
  - verilog/sample_history.sv
  - verilog/frame_sequencer.sv
  - verilog/poly_bank.sv
  - verilog/output_stage.sv
  - verilog/fir_decim.sv
  - target: test
    files:
      - verif/tb_fir_decim.sv

//--- all.f
+incdir+verilog
verilog/fir_pkg.sv
verilog/sample_history.sv
verilog/frame_sequencer.sv
verilog/poly_bank.sv
verilog/output_stage.sv
verilog/fir_decim.sv
verif/tb_fir_decim.sv

//--- verif/tb_fir_decim.sv
`default_nettype none

`include "fir_settings.svh"

module tb_fir_decim;

   timeunit 1ns;
   timeprecision 1ps;

   import fir_pkg::*;

   localparam int M    = `FIR_DECIM;
   localparam int L    = `FIR_BANK_LEN;
   localparam int N    = M * L;
   localparam int DROP = `FIR_DROP_LSB;

   localparam longint OUT_MAX    = (longint'(1) <<< (`FIR_OUT_W - 1)) - 1;
   localparam longint OUT_MIN    = -(longint'(1) <<< (`FIR_OUT_W - 1));
   localparam int     SAMPLE_MAX = (1 <<< (`FIR_SAMPLE_W - 1)) - 1;
   localparam int     SAMPLE_MIN = -(1 <<< (`FIR_SAMPLE_W - 1));
   localparam int     COEF_MAX   = (1 <<< (`FIR_COEF_W - 1)) - 1;
   localparam int     COEF_MIN   = -(1 <<< (`FIR_COEF_W - 1));

   // impulse, random, gaps, rounding, extremes
   localparam int TEST_FRAMES = 4 + 30 + 20 + 6 + 3 * L;
   localparam int CYCLE_LIMIT = 2 * (TEST_FRAMES * M + 50);

   logic     clk;
   logic     rst_n;
   sample_t  din;
   logic     din_valid;
   logic     coef_we;
   coef_wr_t coef_wr;
   out_t     dout;
   logic     dvalid;

   // reference model state
   coef_t       coef_m [M][L];
   sample_t     hist_m [N];
   int          phase_m;
   out_t        exp_q [$];
   out_t        exp_head;
   int          exp_count;
   logic        frame_close;
   logic        out_seen;
   logic [31:0] lfsr;
   int          errors;
   int          cycles;

   fir_decim uut (
      .clk       (clk),
      .rst_n     (rst_n),
      .din       (din),
      .din_valid (din_valid),
      .coef_we   (coef_we),
      .coef_wr   (coef_wr),
      .dout      (dout),
      .dvalid    (dvalid)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return v;
   endfunction

   // exact convolution, then round half to even and clamp
   function automatic out_t expected_output();
      longint s;
      longint q;
      longint r;
      longint half;
      s = 0;
      for (int k = 0; k < N; k++) begin
         s += longint'(coef_m[k % M][k / M]) * longint'(hist_m[k]);
      end
      q    = s >>> DROP;
      r    = s - (q <<< DROP);
      half = longint'(1) <<< (DROP - 1);
      if (r > half || (r == half && q[0])) begin
         q++;
      end
      if (q > OUT_MAX) begin
         q = OUT_MAX;
      end else if (q < OUT_MIN) begin
         q = OUT_MIN;
      end
      return out_t'(q);
   endfunction

   function automatic void refresh_head();
      exp_count = exp_q.size();
      exp_head  = (exp_q.size() > 0) ? exp_q[0] : '0;
   endfunction

   task automatic idle_cycle();
      @(posedge clk);
      #2;
      din_valid   = 1'b0;
      coef_we     = 1'b0;
      frame_close = 1'b0;
   endtask

   task automatic write_coef(input int ph, input int idx, input coef_t v);
      @(posedge clk);
      #2;
      din_valid     = 1'b0;
      frame_close   = 1'b0;
      coef_we       = 1'b1;
      coef_wr.phase = phase_t'(ph);
      coef_wr.idx   = tap_idx_t'(idx);
      coef_wr.value = v;
      coef_m[ph][idx] = v;
   endtask

   task automatic send_sample(input sample_t s);
      @(posedge clk);
      #2;
      coef_we   = 1'b0;
      din       = s;
      din_valid = 1'b1;
      for (int i = N - 1; i > 0; i--) begin
         hist_m[i] = hist_m[i-1];
      end
      hist_m[0] = s;
      if (phase_m == M - 1) begin
         frame_close = 1'b1;
         phase_m     = 0;
         exp_q.push_back(expected_output());
         refresh_head();
      end else begin
         frame_close = 1'b0;
         phase_m++;
      end
   endtask

   task automatic fill_coefs(input coef_t v);
      for (int p = 0; p < M; p++) begin
         for (int j = 0; j < L; j++) begin
            write_coef(p, j, v);
         end
      end
   endtask

   task automatic drain_outputs();
      idle_cycle();
      while (exp_q.size() != 0) begin
         idle_cycle();
      end
      repeat (2) idle_cycle();
   endtask

   task automatic send_const_frames(input sample_t s, input int frames);
      for (int i = 0; i < frames * M; i++) begin
         send_sample(s);
      end
      drain_outputs();
   endtask

   // single tap at phase 3, index 2 shows up at delay 2*M + 3
   task automatic impulse_test();
      write_coef(3, 2, coef_t'(16384));
      for (int i = 0; i < 4 * M; i++) begin
         send_sample((i == 16) ? sample_t'(1024) : sample_t'(0));
      end
      drain_outputs();
   endtask

   task automatic random_test(input int frames, input bit gaps);
      for (int p = 0; p < M; p++) begin
         for (int j = 0; j < L; j++) begin
            write_coef(p, j, coef_t'(rand_bits(16)));
         end
      end
      for (int i = 0; i < frames * M; i++) begin
         if (gaps && rand_bits(2) == 0) begin
            idle_cycle();
         end
         send_sample(sample_t'(rand_bits(12)));
      end
      drain_outputs();
   endtask

   // newest sample 1024 times odd multiples of half an output step
   task automatic rounding_test();
      int odd [6];
      odd = '{1, 3, 5, 7, -1, -3};
      fill_coefs('0);
      foreach (odd[i]) begin
         write_coef(0, 0, coef_t'(odd[i] * (1 <<< (DROP - 11))));
         for (int k = 0; k < M - 1; k++) begin
            send_sample('0);
         end
         send_sample(sample_t'(1024));
         drain_outputs();
      end
   endtask

   task automatic extreme_test();
      fill_coefs(coef_t'(COEF_MIN));
      send_const_frames(sample_t'(SAMPLE_MIN), L);
      send_const_frames(sample_t'(SAMPLE_MAX), L);
      fill_coefs(coef_t'(COEF_MAX));
      send_const_frames(sample_t'(SAMPLE_MAX), L);
   endtask

   task automatic finish_run();
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   endtask

   // retire one expected value per output pulse
   always @(posedge clk) begin
      if (rst_n && dvalid) begin
         out_seen = 1'b1;
         if (exp_q.size() > 0) begin
            void'(exp_q.pop_front());
         end
         refresh_head();
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         errors++;
         $display("timeout after %0d cycles with %0d outputs still expected",
                  cycles, exp_q.size());
         finish_run();
      end
   end

   a_latency: assert property (@(posedge clk) disable iff (!rst_n)
      frame_close |-> ##(L + 3) dvalid)
      else begin
         errors++;
         $display("missing output %0d cycles after a frame end", L + 3);
      end

   a_no_stray: assert property (@(posedge clk) disable iff (!rst_n)
      dvalid |-> $past(frame_close, L + 3))
      else begin
         errors++;
         $display("dvalid without a frame end %0d cycles earlier", L + 3);
      end

   a_expected: assert property (@(posedge clk) disable iff (!rst_n)
      dvalid |-> exp_count > 0)
      else begin
         errors++;
         $display("unexpected dvalid with no output pending");
      end

   a_dout: assert property (@(posedge clk) disable iff (!rst_n)
      (dvalid && exp_count > 0) |-> dout == exp_head)
      else begin
         errors++;
         $display("CHECK FAILED: dout = %h, expected %h",
                  $sampled(dout), $sampled(exp_head));
      end

   a_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
      (!out_seen && !dvalid) |-> dout == '0)
      else begin
         errors++;
         $display("CHECK FAILED: dout = %h before first output, expected 0",
                  $sampled(dout));
      end

   initial begin
      rst_n       = 1'b0;
      din         = '0;
      din_valid   = 1'b0;
      coef_we     = 1'b0;
      coef_wr     = '0;
      frame_close = 1'b0;
      out_seen    = 1'b0;
      lfsr        = 32'h3b68_34c7;
      errors      = 0;
      cycles      = 0;
      phase_m     = 0;
      for (int i = 0; i < N; i++) begin
         hist_m[i] = '0;
      end
      for (int p = 0; p < M; p++) begin
         for (int j = 0; j < L; j++) begin
            coef_m[p][j] = '0;
         end
      end
      refresh_head();
      repeat (3) @(posedge clk);
      #2;
      rst_n = 1'b1;
      repeat (5) idle_cycle();

      impulse_test();
      random_test(30, 1'b0);
      random_test(20, 1'b1);
      rounding_test();
      extreme_test();

      if (exp_q.size() != 0) begin
         errors++;
         $display("%0d outputs never arrived", exp_q.size());
      end
      finish_run();
   end

endmodule

`default_nettype wire

//--- verilog/fir_decim.sv
`default_nettype none

`include "fir_settings.svh"

module fir_decim (
   input  logic               clk,
   input  logic               rst_n,
   input  fir_pkg::sample_t   din,
   input  logic               din_valid,
   input  logic               coef_we,
   input  fir_pkg::coef_wr_t  coef_wr,
   output fir_pkg::out_t      dout,
   output logic               dvalid
);

   import fir_pkg::*;

   localparam int M = `FIR_DECIM;

   bank_taps_t bank_taps [M];
   acc_t       bank_acc [M];
   logic       mac_start;
   logic       mac_first;
   tap_idx_t   tap_idx;
   logic       sum_en;

   sample_history u_history (
      .clk       (clk),
      .rst_n     (rst_n),
      .din       (din),
      .din_valid (din_valid),
      .bank_taps (bank_taps)
   );

   frame_sequencer u_sequencer (
      .clk       (clk),
      .rst_n     (rst_n),
      .din_valid (din_valid),
      .mac_start (mac_start),
      .mac_first (mac_first),
      .tap_idx   (tap_idx),
      .sum_en    (sum_en)
   );

   // one serial MAC per polyphase branch
   for (genvar p = 0; p < M; p++) begin : g_bank
      poly_bank #(
         .PHASE (p)
      ) u_bank (
         .clk       (clk),
         .rst_n     (rst_n),
         .coef_we   (coef_we),
         .coef_wr   (coef_wr),
         .taps      (bank_taps[p]),
         .mac_start (mac_start),
         .mac_first (mac_first),
         .tap_idx   (tap_idx),
         .acc       (bank_acc[p])
      );
   end

   output_stage u_output (
      .clk      (clk),
      .rst_n    (rst_n),
      .bank_acc (bank_acc),
      .sum_en   (sum_en),
      .dout     (dout),
      .dvalid   (dvalid)
   );

endmodule

`default_nettype wire

//--- verilog/fir_pkg.sv
`default_nettype none

`include "fir_settings.svh"

package fir_pkg;

   typedef logic signed [`FIR_SAMPLE_W-1:0] sample_t;
   typedef logic signed [`FIR_COEF_W-1:0]   coef_t;
   typedef logic signed [`FIR_ACC_W-1:0]    acc_t;
   typedef logic signed [`FIR_OUT_W-1:0]    out_t;

   // bank number and tap index within a bank
   typedef logic [$clog2(`FIR_DECIM)-1:0]    phase_t;
   typedef logic [$clog2(`FIR_BANK_LEN)-1:0] tap_idx_t;

   // one coefficient write, addressed by bank and tap
   typedef struct packed {
      phase_t   phase;
      tap_idx_t idx;
      coef_t    value;
   } coef_wr_t;

   typedef enum logic [1:0] {
      SEQ_IDLE,
      SEQ_MAC,
      SEQ_SUM
   } seq_state_e;

   // element j is history sample j*M + p for bank p
   typedef sample_t [`FIR_BANK_LEN-1:0] bank_taps_t;

endpackage

`default_nettype wire

//--- verilog/fir_settings.svh
`ifndef FIR_SETTINGS_SVH
`define FIR_SETTINGS_SVH

// decimation factor M and taps per polyphase bank L
`define FIR_DECIM       20
`define FIR_BANK_LEN    6

// datapath widths
`define FIR_SAMPLE_W    12
`define FIR_COEF_W      16
`define FIR_ACC_W       35
`define FIR_OUT_W       14

// extra gain reduction on top of the coefficient scaling
`define FIR_NORM_SHIFT  4

// low bits removed from the bank sum before saturation
`define FIR_DROP_LSB    (`FIR_COEF_W + `FIR_NORM_SHIFT)

`endif

//--- verilog/frame_sequencer.sv
`default_nettype none

`include "fir_settings.svh"

module frame_sequencer (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               din_valid,
   output logic               mac_start,
   output logic               mac_first,
   output fir_pkg::tap_idx_t  tap_idx,
   output logic               sum_en
);

   import fir_pkg::*;

   localparam int M = `FIR_DECIM;
   localparam int L = `FIR_BANK_LEN;

   localparam phase_t   LAST_PHASE = phase_t'(M - 1);
   localparam tap_idx_t LAST_TAP   = tap_idx_t'(L - 1);

   phase_t     phase;
   logic       frame_end;
   seq_state_e state;

   // strobe that closes a frame of M samples
   assign frame_end = din_valid && (phase == LAST_PHASE);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         phase     <= '0;
         mac_start <= 1'b0;
      end else begin
         mac_start <= frame_end;
         if (din_valid) begin
            if (phase == LAST_PHASE) begin
               phase <= '0;
            end else begin
               phase <= phase + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= SEQ_IDLE;
         tap_idx <= '0;
      end else begin
         case (state)
            SEQ_IDLE: begin
               if (mac_start) begin
                  state   <= SEQ_MAC;
                  tap_idx <= '0;
               end
            end
            SEQ_MAC: begin
               if (tap_idx == LAST_TAP) begin
                  state <= SEQ_SUM;
               end else begin
                  tap_idx <= tap_idx + 1'b1;
               end
            end
            SEQ_SUM: begin
               state   <= SEQ_IDLE;
               tap_idx <= '0;
            end
            default: state <= SEQ_IDLE;
         endcase
      end
   end

   assign mac_first = (state == SEQ_MAC) && (tap_idx == '0);
   assign sum_en    = (state == SEQ_SUM);

   // a frame must finish its MAC before the next one closes
   if (L > M) begin : g_len_check
      $error("bank length exceeds decimation factor");
   end

   a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
      mac_start |-> state == SEQ_IDLE);

   // sum follows the last tap
   a_sum_after_mac: assert property (@(posedge clk) disable iff (!rst_n)
      mac_start |-> ##(L + 1) sum_en);

endmodule

`default_nettype wire

//--- verilog/output_stage.sv
`default_nettype none

`include "fir_settings.svh"

module output_stage (
   input  logic           clk,
   input  logic           rst_n,
   input  fir_pkg::acc_t  bank_acc [`FIR_DECIM],
   input  logic           sum_en,
   output fir_pkg::out_t  dout,
   output logic           dvalid
);

   import fir_pkg::*;

   localparam int M     = `FIR_DECIM;
   localparam int ACC_W = `FIR_ACC_W;
   localparam int DROP  = `FIR_DROP_LSB;
   localparam int OUT_W = `FIR_OUT_W;
   localparam int Q_W   = ACC_W - DROP;

   // one guard bit above the quotient for the round increment
   localparam logic signed [Q_W:0] SAT_MAX = (1 <<< (OUT_W - 1)) - 1;
   localparam logic signed [Q_W:0] SAT_MIN = -(1 <<< (OUT_W - 1));

   acc_t                   sum;
   logic signed [Q_W-1:0]  quot;
   logic                   round_up;
   logic signed [Q_W:0]    rounded;
   out_t                   sat;

   always_comb begin
      sum = '0;
      for (int p = 0; p < M; p++) begin
         sum = sum + bank_acc[p];
      end
   end

   // floor quotient, then round half to even
   assign quot     = sum[ACC_W-1:DROP];
   assign round_up = sum[DROP-1] && ((|sum[DROP-2:0]) || quot[0]);
   assign rounded  = $signed({quot[Q_W-1], quot}) + $signed({1'b0, round_up});

   always_comb begin
      if (rounded > SAT_MAX) begin
         sat = SAT_MAX[OUT_W-1:0];
      end else if (rounded < SAT_MIN) begin
         sat = SAT_MIN[OUT_W-1:0];
      end else begin
         sat = rounded[OUT_W-1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dout   <= '0;
         dvalid <= 1'b0;
      end else begin
         dvalid <= sum_en;
         if (sum_en) begin
            dout <= sat;
         end
      end
   end

   // one output pulse per summed frame
   a_dvalid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      sum_en |=> !sum_en);

endmodule

`default_nettype wire

//--- verilog/poly_bank.sv
`default_nettype none

`include "fir_settings.svh"

module poly_bank #(
   parameter int unsigned PHASE = 0
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 coef_we,
   input  fir_pkg::coef_wr_t    coef_wr,
   input  fir_pkg::bank_taps_t  taps,
   input  logic                 mac_start,
   input  logic                 mac_first,
   input  fir_pkg::tap_idx_t    tap_idx,
   output fir_pkg::acc_t        acc
);

   import fir_pkg::*;

   localparam int L = `FIR_BANK_LEN;

   localparam tap_idx_t LAST_TAP = tap_idx_t'(L - 1);

   coef_t      coef_r [L];
   bank_taps_t snap;
   logic       mac_active;
   coef_t      cur_coef;
   sample_t    cur_sample;
   acc_t       prod;

   // only writes for this bank land here
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < L; i++) begin
            coef_r[i] <= '0;
         end
      end else if (coef_we && (coef_wr.phase == phase_t'(PHASE))) begin
         coef_r[coef_wr.idx] <= coef_wr.value;
      end
   end

   // freeze the slice so the line can keep shifting during the MAC
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         snap <= '0;
      end else if (mac_start) begin
         snap <= taps;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mac_active <= 1'b0;
      end else if (mac_start) begin
         mac_active <= 1'b1;
      end else if (mac_active && (tap_idx == LAST_TAP)) begin
         mac_active <= 1'b0;
      end
   end

   assign cur_coef   = coef_r[tap_idx];
   assign cur_sample = sample_t'(snap[tap_idx]);

   // both operands signed, extended to the accumulator width
   assign prod = cur_coef * cur_sample;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         acc <= '0;
      end else if (mac_active) begin
         if (mac_first) begin
            acc <= prod;
         end else begin
            acc <= acc + prod;
         end
      end
   end

   // sequencer index must stay inside the bank while it is used
   a_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
      (mac_first || mac_active) |-> tap_idx <= LAST_TAP);

endmodule

`default_nettype wire

//--- verilog/sample_history.sv
`default_nettype none

`include "fir_settings.svh"

module sample_history (
   input  logic                 clk,
   input  logic                 rst_n,
   input  fir_pkg::sample_t     din,
   input  logic                 din_valid,
   output fir_pkg::bank_taps_t  bank_taps [`FIR_DECIM]
);

   import fir_pkg::*;

   localparam int M = `FIR_DECIM;
   localparam int L = `FIR_BANK_LEN;
   localparam int N = M * L;

   // index 0 holds the most recently accepted sample
   sample_t hist [N];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < N; i++) begin
            hist[i] <= '0;
         end
      end else if (din_valid) begin
         hist[0] <= din;
         for (int i = 1; i < N; i++) begin
            hist[i] <= hist[i-1];
         end
      end
   end

   // strided slices, bank 0 sees the newest sample
   always_comb begin
      for (int p = 0; p < M; p++) begin
         for (int j = 0; j < L; j++) begin
            bank_taps[p][j] = hist[j*M + p];
         end
      end
   end

endmodule

`default_nettype wire
